// ==== Makefile ====
# Verilator build and run of the feature-value bank testbench

VERILATOR ?= verilator
TOP       ?= fv_bank_tb
FILELIST  ?= fv_bank.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/fv_bank_cntl.sv ====
//##################################################
// bank controller, shares the SRAM between serial
// load, edge write, edge read and the node stream
//##################################################
`timescale 1ns/10ps

module fv_bank_cntl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stream_begin,
    input  logic [fv_cfg_pkg::fv_num_w-1:0] fv_num,
    fv_load_if.cntl                       load,
    fv_req_if.cntl                        cmd,
    output logic                          cen,
    output logic                          wen,
    output fv_cfg_pkg::addr_t             addr,
    output fv_cfg_pkg::line_t             wdata,
    input  fv_cfg_pkg::line_t             rdata,
    output logic                          sm_valid,
    output logic                          sm_sos,
    output logic                          sm_eos,
    output fv_cfg_pkg::addr_t             sm_addr,
    output fv_cfg_pkg::line_t             sm_data,
    output logic                          edge_valid,
    output logic                          edge_sos,
    output logic                          edge_eos,
    output fv_cfg_pkg::tag_t              edge_tag,
    output fv_cfg_pkg::line_t             edge_data,
    output logic                          available
);
    import fv_cfg_pkg::*;
    import fv_msg_pkg::*;

    bank_state_t           state;
    logic [line_idx_w:0]   lines_q;
    logic [line_idx_w:0]   lines_next;
    logic [line_idx_w:0]   line_cnt;
    logic [fv_num_w:0]     fv_sum;
    node_t                 node_cnt;
    addr_t                 load_addr;
    line_t                 load_data;
    logic                  wr_pend;
    logic                  last_line;
    logic                  rd_issue;
    logic                  rd_sos;
    logic                  rd_eos;
    addr_t                 rd_addr;
    // first pipeline stage, the cycle the SRAM is reading
    logic                  p1_valid;
    logic                  p1_edge;
    logic                  p1_sos;
    logic                  p1_eos;
    addr_t                 p1_addr;

    // lines per node, fv_num rounded up to whole lines
    assign fv_sum     = {1'b0, fv_num} + (fv_num_w + 1)'(feats_per_line - 1);
    assign lines_next = (line_idx_w + 1)'(fv_sum >> $clog2(feats_per_line));

    assign available = (state == ST_IDLE);
    assign last_line = (line_cnt == lines_q - 1'b1);

    always_comb begin
        rd_issue = 1'b0;
        rd_sos   = 1'b0;
        rd_eos   = 1'b0;
        rd_addr  = {node_cnt, line_cnt[line_idx_w-1:0]};
        if (state == ST_READ) begin
            rd_issue = (line_cnt != lines_q);
            rd_sos   = (line_cnt == '0);
            rd_eos   = last_line;
            rd_addr  = {cmd.cmd_node, line_cnt[line_idx_w-1:0]};
        end else if (state == ST_STREAM) begin
            rd_issue = 1'b1;
            rd_sos   = (line_cnt == '0) && (node_cnt == '0);
            rd_eos   = last_line && (node_cnt == node_t'(num_nodes - 1));
        end
    end

    // one SRAM access per cycle, load write first
    always_comb begin
        cen   = 1'b1;
        wen   = 1'b1;
        addr  = rd_addr;
        wdata = load_data;
        if (wr_pend) begin
            cen  = 1'b0;
            wen  = 1'b0;
            addr = load_addr;
        end else if (state == ST_WRITE) begin
            cen   = 1'b0;
            wen   = 1'b0;
            addr  = {cmd.cmd_node, cmd.cmd_line};
            wdata = cmd.cmd_data;
        end else if (rd_issue) begin
            cen = 1'b0;
        end
    end

    // write completes at once, a read ends with its eos beat
    assign cmd.cmd_done = (state == ST_WRITE) || edge_eos;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= ST_IDLE;
            lines_q   <= '0;
            line_cnt  <= '0;
            node_cnt  <= '0;
            load_addr <= '0;
            wr_pend   <= 1'b0;
        end else begin
            wr_pend <= load.word_valid;
            case (state)
                ST_IDLE: begin
                    line_cnt <= '0;
                    node_cnt <= '0;
                    if (load.frame_active) begin
                        state     <= ST_LOAD;
                        load_addr <= '0;
                    end else if (cmd.cmd_valid) begin
                        state   <= (cmd.cmd_op == OP_WRITE) ? ST_WRITE : ST_READ;
                        lines_q <= lines_next;
                    end else if (stream_begin) begin
                        state   <= ST_STREAM;
                        lines_q <= lines_next;
                    end
                end
                ST_LOAD: begin
                    if (wr_pend) load_addr <= load_addr + 1'b1;
                    if (load.frame_done) state <= ST_IDLE;
                end
                ST_WRITE: state <= ST_IDLE;
                ST_READ: begin
                    if (rd_issue) line_cnt <= line_cnt + 1'b1;
                    // hold until the port has seen the last beat
                    if (cmd.cmd_done) state <= ST_IDLE;
                end
                ST_STREAM: begin
                    if (last_line) begin
                        line_cnt <= '0;
                        node_cnt <= node_cnt + 1'b1;
                        if (rd_eos) state <= ST_IDLE;
                    end else begin
                        line_cnt <= line_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // load word is written the cycle after word_valid
    always_ff @(posedge clk) begin
        if (load.word_valid) load_data <= load.word;
    end

    // markers follow each read through the SRAM latency
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            p1_valid   <= 1'b0;
            p1_edge    <= 1'b0;
            p1_sos     <= 1'b0;
            p1_eos     <= 1'b0;
            edge_valid <= 1'b0;
            edge_sos   <= 1'b0;
            edge_eos   <= 1'b0;
            sm_valid   <= 1'b0;
            sm_sos     <= 1'b0;
            sm_eos     <= 1'b0;
        end else begin
            p1_valid   <= rd_issue;
            p1_edge    <= (state == ST_READ);
            p1_sos     <= rd_sos;
            p1_eos     <= rd_eos;
            edge_valid <= p1_valid && p1_edge;
            edge_sos   <= p1_valid && p1_edge && p1_sos;
            edge_eos   <= p1_valid && p1_edge && p1_eos;
            sm_valid   <= p1_valid && !p1_edge;
            sm_sos     <= p1_valid && !p1_edge && p1_sos;
            sm_eos     <= p1_valid && !p1_edge && p1_eos;
        end
    end

    always_ff @(posedge clk) begin
        p1_addr   <= rd_addr;
        sm_addr   <= p1_addr;
        sm_data   <= rdata;
        edge_data <= rdata;
        edge_tag  <= cmd.cmd_tag;
    end

    // edge beats drain before the read state hands back the port
    a_edge_in_read: assert property (
        @(posedge clk) disable iff (!reset)
        edge_valid |-> (state == ST_READ)
    );

endmodule

// ==== design/fv_bank_top.sv ====
//##################################################
// feature-value bank top, serial receiver and edge
// port feeding the controller and its SRAM
//##################################################
`timescale 1ns/10ps

module fv_bank_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ser_sos,
    input  logic                            ser_eos,
    input  logic                            ser_bit,
    input  logic                            req,
    input  fv_msg_pkg::fv_op_t              op,
    input  fv_cfg_pkg::node_t               node_id,
    input  fv_cfg_pkg::line_idx_t           line_idx,
    input  fv_cfg_pkg::line_t               wr_data,
    input  fv_cfg_pkg::tag_t                pe_tag,
    output logic                            ack,
    input  logic                            stream_begin,
    input  logic [fv_cfg_pkg::fv_num_w-1:0] fv_num,
    output logic                            sm_valid,
    output logic                            sm_sos,
    output logic                            sm_eos,
    output fv_cfg_pkg::addr_t               sm_addr,
    output fv_cfg_pkg::line_t               sm_data,
    output logic                            edge_valid,
    output logic                            edge_sos,
    output logic                            edge_eos,
    output fv_cfg_pkg::tag_t                edge_tag,
    output fv_cfg_pkg::line_t               edge_data,
    output logic                            available
);

    fv_load_if load_bus ();
    fv_req_if  cmd_bus ();

    // SRAM side of the controller
    logic              cen;
    logic              wen;
    fv_cfg_pkg::addr_t addr;
    fv_cfg_pkg::line_t wdata;
    fv_cfg_pkg::line_t rdata;

    fv_serial_rx i_serial_rx (
        .clk     (clk),
        .reset   (reset),
        .ser_sos (ser_sos),
        .ser_eos (ser_eos),
        .ser_bit (ser_bit),
        .load    (load_bus.rx)
    );

    fv_req_port i_req_port (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .op       (op),
        .node_id  (node_id),
        .line_idx (line_idx),
        .wr_data  (wr_data),
        .pe_tag   (pe_tag),
        .ack      (ack),
        .cmd      (cmd_bus.port)
    );

    fv_bank_cntl i_bank_cntl (
        .clk          (clk),
        .reset        (reset),
        .stream_begin (stream_begin),
        .fv_num       (fv_num),
        .load         (load_bus.cntl),
        .cmd          (cmd_bus.cntl),
        .cen          (cen),
        .wen          (wen),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .sm_valid     (sm_valid),
        .sm_sos       (sm_sos),
        .sm_eos       (sm_eos),
        .sm_addr      (sm_addr),
        .sm_data      (sm_data),
        .edge_valid   (edge_valid),
        .edge_sos     (edge_sos),
        .edge_eos     (edge_eos),
        .edge_tag     (edge_tag),
        .edge_data    (edge_data),
        .available    (available)
    );

    fv_sram_bank i_sram_bank (
        .clk   (clk),
        .cen   (cen),
        .wen   (wen),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata)
    );

endmodule

// ==== design/fv_cfg_pkg.sv ====
//##################################################
// geometry of one feature-value bank and the vector
// types built from it, shared by RTL and testbench
//##################################################
package fv_cfg_pkg;

    // one line holds four 16-bit features
    localparam int feat_w         = 16;
    localparam int feats_per_line = 4;
    localparam int line_w         = feat_w * feats_per_line;

    // bank holds every node at its largest size
    localparam int num_nodes      = 32;
    localparam int max_lines      = 4;
    localparam int bank_depth     = num_nodes * max_lines;

    localparam int addr_w         = $clog2(bank_depth);
    localparam int node_w         = $clog2(num_nodes);
    localparam int line_idx_w     = $clog2(max_lines);

    // fv_num runs 1..16, so one extra bit over the log
    localparam int fv_num_w       = $clog2(max_lines * feats_per_line) + 1;
    localparam int tag_w          = 2;

    // bit position inside a serial word
    localparam int bit_cnt_w      = $clog2(line_w);

    typedef logic [line_w-1:0]     line_t;
    typedef logic [addr_w-1:0]     addr_t;
    typedef logic [node_w-1:0]     node_t;
    typedef logic [line_idx_w-1:0] line_idx_t;
    typedef logic [tag_w-1:0]      tag_t;

endpackage

// ==== design/fv_load_if.sv ====
//##################################################
// deserialized load words, serial receiver to bank
// controller, with frame open and close markers
//##################################################
`timescale 1ns/10ps

interface fv_load_if;
    import fv_cfg_pkg::*;

    logic  frame_active;
    // one-cycle pulse, no back-pressure
    logic  word_valid;
    line_t word;
    logic  frame_done;

    modport rx (
        output frame_active,
        output word_valid,
        output word,
        output frame_done
    );

    modport cntl (
        input frame_active,
        input word_valid,
        input word,
        input frame_done
    );

endinterface

// ==== design/fv_msg_pkg.sv ====
//##################################################
// edge opcode and controller state encodings
//##################################################
package fv_msg_pkg;

    // edge PE operation, one per handshake
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } fv_op_t;

    // bank controller states
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_LOAD   = 3'd1,
        ST_WRITE  = 3'd2,
        ST_READ   = 3'd3,
        ST_STREAM = 3'd4
    } bank_state_t;

endpackage

// ==== design/fv_req_if.sv ====
//##################################################
// accepted edge command, request port to controller,
// with the completion pulse going back
//##################################################
`timescale 1ns/10ps

interface fv_req_if;
    import fv_cfg_pkg::*;
    import fv_msg_pkg::*;

    logic      cmd_valid;
    fv_op_t    cmd_op;
    node_t     cmd_node;
    line_idx_t cmd_line;
    line_t     cmd_data;
    tag_t      cmd_tag;
    logic      cmd_done;

    modport port (
        output cmd_valid, cmd_op, cmd_node, cmd_line, cmd_data, cmd_tag,
        input  cmd_done
    );

    modport cntl (
        input  cmd_valid, cmd_op, cmd_node, cmd_line, cmd_data, cmd_tag,
        output cmd_done
    );

endinterface

// ==== design/fv_req_port.sv ====
//##################################################
// four-phase req/ack front end for one edge PE,
// holds the command until the controller finishes
//##################################################
`timescale 1ns/10ps

module fv_req_port (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  fv_msg_pkg::fv_op_t    op,
    input  fv_cfg_pkg::node_t     node_id,
    input  fv_cfg_pkg::line_idx_t line_idx,
    input  fv_cfg_pkg::line_t     wr_data,
    input  fv_cfg_pkg::tag_t      pe_tag,
    output logic                  ack,
    fv_req_if.port                cmd
);

    typedef enum logic [1:0] {
        P_WAIT = 2'd0,
        P_HOLD = 2'd1,
        P_ACK  = 2'd2
    } port_state_t;

    port_state_t state;

    assign cmd.cmd_valid = (state == P_HOLD);
    assign ack           = (state == P_ACK);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= P_WAIT;
        end else begin
            case (state)
                P_WAIT:  if (req) state <= P_HOLD;
                P_HOLD:  if (cmd.cmd_done) state <= P_ACK;
                // ack falls the cycle after req drops
                P_ACK:   if (!req) state <= P_WAIT;
                default: state <= P_WAIT;
            endcase
        end
    end

    // command fields, captured on acceptance
    always_ff @(posedge clk) begin
        if (state == P_WAIT && req) begin
            cmd.cmd_op   <= op;
            cmd.cmd_node <= node_id;
            cmd.cmd_line <= line_idx;
            cmd.cmd_data <= wr_data;
            cmd.cmd_tag  <= pe_tag;
        end
    end

    // PE keeps req up until it sees ack
    a_req_held: assert property (
        @(posedge clk) disable iff (!reset)
        (state == P_HOLD) |-> req
    );

endmodule

// ==== design/fv_serial_rx.sv ====
//##################################################
// serial load receiver, assembles framed bits into
// 64-bit lines, MSB first, for the bank controller
//##################################################
`timescale 1ns/10ps

module fv_serial_rx (
    input  logic clk,
    input  logic reset,
    input  logic ser_sos,
    input  logic ser_eos,
    input  logic ser_bit,
    fv_load_if.rx load
);
    import fv_cfg_pkg::*;

    logic [bit_cnt_w-1:0] bit_cnt;
    line_t                shift_q;

    assign load.word = shift_q;

    // ser_sos and ser_eos are marker cycles and carry no data bit
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            load.frame_active <= 1'b0;
            load.word_valid   <= 1'b0;
            load.frame_done   <= 1'b0;
            bit_cnt           <= '0;
        end else begin
            load.word_valid <= 1'b0;
            load.frame_done <= 1'b0;
            if (!load.frame_active) begin
                if (ser_sos) begin
                    load.frame_active <= 1'b1;
                    bit_cnt           <= '0;
                end
            end else if (ser_eos) begin
                // partial word is simply left in the shifter
                load.frame_active <= 1'b0;
                load.frame_done   <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == bit_cnt_w'(line_w - 1)) begin
                    load.word_valid <= 1'b1;
                end
            end
        end
    end

    // data shifter
    always_ff @(posedge clk) begin
        if (load.frame_active && !ser_eos) begin
            shift_q <= {shift_q[line_w-2:0], ser_bit};
        end
    end

    // no new frame marker inside an open frame
    a_sos_outside_frame: assert property (
        @(posedge clk) disable iff (!reset)
        load.frame_active |-> !ser_sos
    );

endmodule

// ==== design/fv_sram_bank.sv ====
//##################################################
// single-port line SRAM, active-low enables,
// read data one cycle after the address
//##################################################
`timescale 1ns/10ps

module fv_sram_bank (
    input  logic              clk,
    input  logic              cen,
    input  logic              wen,
    input  fv_cfg_pkg::addr_t addr,
    input  fv_cfg_pkg::line_t wdata,
    output fv_cfg_pkg::line_t rdata
);
    import fv_cfg_pkg::*;

    line_t mem [bank_depth];

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== fv_bank.f ====
design/fv_cfg_pkg.sv
design/fv_msg_pkg.sv
design/fv_load_if.sv
design/fv_req_if.sv
design/fv_serial_rx.sv
design/fv_req_port.sv
design/fv_sram_bank.sv
design/fv_bank_cntl.sv
design/fv_bank_top.sv
tb/fv_bank_tb.sv

// ==== tb/fv_bank_tb.sv ====
//##################################################
// self-checking testbench for the feature bank,
// rows of load, edge and stream tests in a loop
//##################################################
`timescale 1ns/10ps

module fv_bank_tb;
    import fv_cfg_pkg::*;
    import fv_msg_pkg::*;

    typedef enum logic [1:0] {
        K_LOAD   = 2'd0,
        K_WRITE  = 2'd1,
        K_READ   = 2'd2,
        K_STREAM = 2'd3
    } test_kind_t;

    // words and tail only matter for load rows
    typedef struct packed {
        test_kind_t kind;
        int         node;
        int         idx;
        int         fvn;
        int         tag;
        int         words;
        int         tail;
    } test_row_t;

    logic                clk;
    logic                reset;
    logic                ser_sos;
    logic                ser_eos;
    logic                ser_bit;
    logic                req;
    fv_op_t              op;
    node_t               node_id;
    line_idx_t           line_idx;
    line_t               wr_data;
    tag_t                pe_tag;
    logic                ack;
    logic                stream_begin;
    logic [fv_num_w-1:0] fv_num;
    logic                sm_valid;
    logic                sm_sos;
    logic                sm_eos;
    addr_t               sm_addr;
    line_t               sm_data;
    logic                edge_valid;
    logic                edge_sos;
    logic                edge_eos;
    tag_t                edge_tag;
    line_t               edge_data;
    logic                available;

    // expected bank contents
    line_t       ref_mem [bank_depth];
    test_row_t   rows [$];
    logic [31:0] lcg_state = 32'h5b3d;
    int          errors = 0;
    int          limit_cycles = 0;

    fv_bank_top i_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic line_t make_line();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    task automatic add_row(input test_kind_t kind, input int node, input int idx,
                           input int fvn, input int tag, input int words, input int tail);
        test_row_t r;
        r.kind  = kind;
        r.node  = node;
        r.idx   = idx;
        r.fvn   = fvn;
        r.tag   = tag;
        r.words = words;
        r.tail  = tail;
        rows.push_back(r);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    // MSB first, one bit per cycle
    task automatic send_bits(input line_t data, input int count);
        line_t shift;
        shift = data;
        for (int i = 0; i < count; i++) begin
            ser_bit = shift[line_w-1];
            shift   = shift << 1;
            @(negedge clk);
        end
    endtask

    task automatic serial_load(input int words, input int tail);
        line_t data;
        ser_sos = 1'b1;
        @(negedge clk);
        ser_sos = 1'b0;
        for (int w = 0; w < words; w++) begin
            data = make_line();
            ref_mem[addr_t'(w)] = data;
            send_bits(data, line_w);
        end
        // unfinished word, never reaches the SRAM
        data = make_line();
        send_bits(data, tail);
        ser_eos = 1'b1;
        @(negedge clk);
        ser_eos = 1'b0;
        // frame_done is up here, the controller leaves ST_LOAD on the next edge
        if (available !== 1'b0) begin
            $display("available was high while the load frame was closing");
            errors++;
        end
        @(negedge clk);
        if (available !== 1'b1) begin
            $display("available did not return high one cycle after frame_done");
            errors++;
        end
    endtask

    // one four-phase handshake, cycle 1 is the negedge after req is sampled
    task automatic edge_request(input test_row_t row);
        int    cyc;
        int    beats;
        int    exp_beats;
        int    first_cyc;
        int    last_cyc;
        int    ack_cyc;
        addr_t exp_addr;
        line_t data;
        data      = make_line();
        exp_beats = (row.fvn + feats_per_line - 1) / feats_per_line;
        fv_num    = fv_num_w'(row.fvn);
        op        = (row.kind == K_WRITE) ? OP_WRITE : OP_READ;
        node_id   = node_t'(row.node);
        line_idx  = line_idx_t'(row.idx);
        wr_data   = data;
        pe_tag    = tag_t'(row.tag);
        req       = 1'b1;
        cyc       = 0;
        beats     = 0;
        first_cyc = 0;
        last_cyc  = 0;
        ack_cyc   = 0;
        while (ack_cyc == 0) begin
            @(negedge clk);
            cyc++;
            if (edge_valid) begin
                exp_addr = {node_t'(row.node), line_idx_t'(beats)};
                if (beats == 0) first_cyc = cyc;
                last_cyc = cyc;
                if (edge_data !== ref_mem[exp_addr])
                    report_mismatch("edge_data", edge_data, ref_mem[exp_addr]);
                if (edge_tag !== tag_t'(row.tag))
                    report_mismatch("edge_tag", 64'(edge_tag), 64'(row.tag));
                if (edge_sos !== (beats == 0))
                    report_mismatch("edge_sos", 64'(edge_sos), 64'(beats == 0));
                if (edge_eos !== (beats == exp_beats - 1))
                    report_mismatch("edge_eos", 64'(edge_eos), 64'(beats == exp_beats - 1));
                beats++;
            end
            if (ack) ack_cyc = cyc;
        end
        if (row.kind == K_WRITE) begin
            if (ack_cyc != 3) begin
                $display("ack rose %0d cycles after req was sampled, not 2", ack_cyc - 1);
                errors++;
            end
            if (beats != 0) begin
                $display("edge beats appeared during a write");
                errors++;
            end
            ref_mem[{node_t'(row.node), line_idx_t'(row.idx)}] = data;
        end else begin
            if (beats != exp_beats) begin
                $display("read gave %0d edge beats, expected %0d", beats, exp_beats);
                errors++;
            end
            if (first_cyc != 4) begin
                $display("first edge beat came %0d cycles after req, not 3", first_cyc - 1);
                errors++;
            end
            if (ack_cyc != last_cyc + 1) begin
                $display("ack did not rise in the cycle after the last edge beat");
                errors++;
            end
        end
        req = 1'b0;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("ack was still high one cycle after req dropped");
            errors++;
        end
    endtask

    task automatic run_stream(input test_row_t row);
        int    lines;
        int    beats;
        int    total;
        logic  done;
        addr_t exp_addr;
        lines = (row.fvn + feats_per_line - 1) / feats_per_line;
        total = num_nodes * lines;
        while (!available) @(negedge clk);
        fv_num       = fv_num_w'(row.fvn);
        stream_begin = 1'b1;
        @(negedge clk);
        stream_begin = 1'b0;
        beats        = 0;
        done         = 1'b0;
        // the beat train must be unbroken
        while (!done) begin
            if (sm_valid) begin
                exp_addr = {node_t'(beats / lines), line_idx_t'(beats % lines)};
                if (sm_addr !== exp_addr)
                    report_mismatch("sm_addr", 64'(sm_addr), 64'(exp_addr));
                if (sm_data !== ref_mem[exp_addr])
                    report_mismatch("sm_data", sm_data, ref_mem[exp_addr]);
                if (sm_sos !== (beats == 0))
                    report_mismatch("sm_sos", 64'(sm_sos), 64'(beats == 0));
                if (sm_eos !== (beats == total - 1))
                    report_mismatch("sm_eos", 64'(sm_eos), 64'(beats == total - 1));
                beats++;
            end else if (beats > 0) begin
                done = 1'b1;
            end
            if (!done) @(negedge clk);
        end
        if (beats != total) begin
            $display("stream gave %0d beats, expected %0d", beats, total);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (reset && sm_valid && edge_valid) begin
            $display("stream and edge beats overlapped at %0t", $time);
            errors++;
        end
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int err_before;
        int failed;
        int cycles;
        reset        = 1'b0;
        ser_sos      = 1'b0;
        ser_eos      = 1'b0;
        ser_bit      = 1'b0;
        req          = 1'b0;
        op           = OP_READ;
        node_id      = '0;
        line_idx     = '0;
        wr_data      = '0;
        pe_tag       = '0;
        stream_begin = 1'b0;
        fv_num       = fv_num_w'(16);
        failed       = 0;
        cycles       = 0;

        //      kind      node idx fv tag words tail
        add_row(K_LOAD,   0,   0,  16, 0, bank_depth, 0);
        add_row(K_READ,   0,   0,  16, 1, 0, 0);
        add_row(K_READ,   13,  0,  16, 2, 0, 0);
        add_row(K_READ,   31,  0,  16, 3, 0, 0);
        add_row(K_WRITE,  5,   2,  16, 0, 0, 0);
        add_row(K_WRITE,  20,  0,  16, 1, 0, 0);
        add_row(K_READ,   5,   0,  16, 1, 0, 0);
        add_row(K_READ,   20,  0,  16, 2, 0, 0);
        add_row(K_READ,   9,   0,  1,  0, 0, 0);
        add_row(K_READ,   9,   0,  5,  3, 0, 0);
        add_row(K_READ,   9,   0,  13, 1, 0, 0);
        add_row(K_STREAM, 0,   0,  8,  0, 0, 0);
        // frame ends part way through its fourth word
        add_row(K_LOAD,   0,   0,  16, 0, 3, 37);
        add_row(K_READ,   0,   0,  16, 2, 0, 0);
        add_row(K_READ,   7,   0,  16, 3, 0, 0);
        add_row(K_STREAM, 0,   0,  4,  0, 0, 0);

        foreach (rows[i]) begin
            case (rows[i].kind)
                K_LOAD:   cycles += rows[i].words * line_w + rows[i].tail + 20;
                K_STREAM: cycles += bank_depth + 40;
                default:  cycles += 40;
            endcase
        end
        limit_cycles = cycles + 500;

        repeat (10) @(negedge clk);
        if (ack !== 1'b0) report_mismatch("ack", 64'(ack), 64'd0);
        if (sm_valid !== 1'b0) report_mismatch("sm_valid", 64'(sm_valid), 64'd0);
        if (edge_valid !== 1'b0) report_mismatch("edge_valid", 64'(edge_valid), 64'd0);
        if (available !== 1'b1) report_mismatch("available", 64'(available), 64'd1);
        reset = 1'b1;
        @(negedge clk);

        foreach (rows[i]) begin
            err_before = errors;
            case (rows[i].kind)
                K_LOAD:   serial_load(rows[i].words, rows[i].tail);
                K_STREAM: run_stream(rows[i]);
                default:  edge_request(rows[i]);
            endcase
            if (errors != err_before) failed++;
            $display("test %0d %s node %0d fv_num %0d: %s", i, rows[i].kind.name(),
                     rows[i].node, rows[i].fvn, (errors == err_before) ? "ok" : "failed");
        end

        $display("tests %0d, failed %0d, errors %0d", rows.size(), failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
